// ==== Bender.yml ====
package:
  name: game_link

sources:
  - include_dirs:
      - design
    files:
      - design/link_pkg.sv
      - design/serial_rx.sv
      - design/serial_tx.sv
      - design/player_table.sv
      - design/tx_scheduler.sv
      - design/game_link.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/game_link_tb.sv

// ==== design/game_link.sv ====
`timescale 1ns/1ps

module game_link (
    input  logic                        clk,
    input  logic                        rst,
    input  link_pkg::player_id_t        player_id,
    input  link_pkg::player_info_t      local_info,
    input  link_pkg::gstate_t           local_game_state,
    input  logic                        line_in,
    output logic                        line_out,
    output link_pkg::player_info_t [3:0] players,
    output link_pkg::gstate_t           game_state,
    output link_pkg::sched_state_t      link_status
);
    import link_pkg::*;

    // receive side
    word_t rx_word;
    logic  rx_valid;
    logic  credit_return;

    // transmit side
    word_t tx_word;
    logic  tx_trigger;
    logic  tx_ready;

    serial_rx u_serial_rx (
        .clk      (clk),
        .rst      (rst),
        .line_in  (line_in),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    player_table u_player_table (
        .clk              (clk),
        .rst              (rst),
        .player_id        (player_id),
        .local_info       (local_info),
        .local_game_state (local_game_state),
        .rx_word          (rx_word),
        .rx_valid         (rx_valid),
        .players          (players),
        .game_state       (game_state),
        .credit_return    (credit_return)
    );

    // ACKs decoded on receive feed credits back to the sender
    tx_scheduler u_tx_scheduler (
        .clk              (clk),
        .rst              (rst),
        .player_id        (player_id),
        .local_info       (local_info),
        .local_game_state (local_game_state),
        .credit_return    (credit_return),
        .tx_ready         (tx_ready),
        .tx_word          (tx_word),
        .tx_trigger       (tx_trigger),
        .link_status      (link_status)
    );

    serial_tx u_serial_tx (
        .clk        (clk),
        .rst        (rst),
        .tx_word    (tx_word),
        .tx_trigger (tx_trigger),
        .line_out   (line_out),
        .tx_ready   (tx_ready)
    );

endmodule

// ==== design/link_defs.svh ====
`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// clock cycles per serial bit on the one-wire link
`define LINK_CLKS_PER_BIT 8

// packets that may be in flight before an ACK is needed
`define LINK_CREDITS 2

// packet type codes in the low bits of a link word
`define LINK_PTYPE_PLAYER 3'b000
`define LINK_PTYPE_ACK    3'b111

`endif

// ==== design/link_pkg.sv ====
package link_pkg;

    // field widths of the link word
    typedef logic [1:0]  player_id_t;
    typedef logic [1:0]  dir_t;
    typedef logic [8:0]  coord_t;
    typedef logic [3:0]  pstate_t;
    typedef logic [2:0]  gstate_t;
    typedef logic [2:0]  ptype_t;
    typedef logic [31:0] word_t;

    // one player's record, 24 bits
    typedef struct packed {
        dir_t    dir;
        coord_t  x;
        coord_t  y;
        pstate_t state;
    } player_info_t;

    // link word, sender id in the top bits and type in the bottom bits
    typedef struct packed {
        player_id_t   sender;
        player_info_t info;
        gstate_t      game;
        ptype_t       ptype;
    } link_packet_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_phase_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_phase_t;

    // shown on the board as the network status
    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_SEND,
        SCHED_HOLD
    } sched_state_t;

endpackage

// ==== design/player_table.sv ====
`timescale 1ns/1ps
`include "link_defs.svh"

module player_table (
    input  logic                        clk,
    input  logic                        rst,
    input  link_pkg::player_id_t        player_id,
    input  link_pkg::player_info_t      local_info,
    input  link_pkg::gstate_t           local_game_state,
    input  link_pkg::word_t             rx_word,
    input  logic                        rx_valid,
    output link_pkg::player_info_t [3:0] players,
    output link_pkg::gstate_t           game_state,
    output logic                        credit_return
);
    import link_pkg::*;

    link_packet_t pkt;
    logic         is_player;
    logic         is_ack;
    logic         is_remote;

    assign pkt       = link_packet_t'(rx_word);
    assign is_player = rx_valid && (pkt.ptype == `LINK_PTYPE_PLAYER);
    assign is_ack    = rx_valid && (pkt.ptype == `LINK_PTYPE_ACK);
    // the hub echoes our own record back too, that one is not trusted
    assign is_remote = is_player && (pkt.sender != player_id);

    always_ff @(posedge clk) begin
        if (rst) begin
            players <= '0;
        end else begin
            if (is_remote) begin
                players[pkt.sender] <= pkt.info;
            end
            // local slot always wins over anything received
            players[player_id] <= local_info;
        end
    end

    // player zero runs the game, everyone else follows its packets
    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= '0;
        end else if (player_id == '0) begin
            game_state <= local_game_state;
        end else if (is_remote && pkt.sender == '0) begin
            game_state <= pkt.game;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= is_ack;
        end
    end

    a_local_slot: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> players[$past(player_id)] == $past(local_info)
    );

endmodule

// ==== design/serial_rx.sv ====
`timescale 1ns/1ps
`include "link_defs.svh"

module serial_rx (
    input  logic            clk,
    input  logic            rst,
    input  logic            line_in,
    output link_pkg::word_t rx_word,
    output logic            rx_valid
);
    import link_pkg::*;

    localparam int CLKS  = `LINK_CLKS_PER_BIT;
    localparam int HALF  = CLKS / 2;
    localparam int CNT_W = $clog2(CLKS);

    logic             sync_q1;
    logic             sync_q2;
    logic             line_prev;
    logic [CNT_W-1:0] cnt;
    logic [4:0]       bit_idx;
    rx_phase_t        phase;
    word_t            shift_q;

    // two flops against metastability, a third one for edge detection
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q1   <= 1'b1;
            sync_q2   <= 1'b1;
            line_prev <= 1'b1;
        end else begin
            sync_q1   <= line_in;
            sync_q2   <= sync_q1;
            line_prev <= sync_q2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (phase)
                RX_IDLE: begin
                    // only a falling edge starts a frame, so a stuck-low line is not read
                    if (line_prev && !sync_q2) begin
                        phase <= RX_START;
                        cnt   <= '0;
                    end
                end
                RX_START: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(HALF - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        // glitch check at the middle of the start bit
                        phase   <= sync_q2 ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CLKS - 1)) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 5'd31) begin
                            phase <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CLKS - 1)) begin
                        cnt      <= '0;
                        rx_valid <= sync_q2;
                        phase    <= RX_IDLE;
                    end
                end
                default: phase <= RX_IDLE;
            endcase
        end
    end

    // data arrives LSB first, shift in from the top
    always_ff @(posedge clk) begin
        if (phase == RX_DATA && cnt == CNT_W'(CLKS - 1)) begin
            shift_q <= {sync_q2, shift_q[31:1]};
        end
    end

    assign rx_word = shift_q;

endmodule

// ==== design/serial_tx.sv ====
`timescale 1ns/1ps
`include "link_defs.svh"

module serial_tx (
    input  logic            clk,
    input  logic            rst,
    input  link_pkg::word_t tx_word,
    input  logic            tx_trigger,
    output logic            line_out,
    output logic            tx_ready
);
    import link_pkg::*;

    localparam int CLKS  = `LINK_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);

    logic [CNT_W-1:0] cnt;
    logic [4:0]       bit_idx;
    tx_phase_t        phase;
    word_t            shift_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= TX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            line_out <= 1'b1;
        end else begin
            case (phase)
                TX_IDLE: begin
                    if (tx_trigger) begin
                        phase    <= TX_START;
                        cnt      <= '0;
                        line_out <= 1'b0;
                    end
                end
                TX_START: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CLKS - 1)) begin
                        cnt      <= '0;
                        bit_idx  <= '0;
                        line_out <= shift_q[0];
                        phase    <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CLKS - 1)) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 5'd31) begin
                            line_out <= 1'b1;
                            phase    <= TX_STOP;
                        end else begin
                            line_out <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CLKS - 1)) begin
                        cnt   <= '0;
                        phase <= TX_IDLE;
                    end
                end
                default: phase <= TX_IDLE;
            endcase
        end
    end

    // word is latched on the trigger, then drops one bit per bit period
    always_ff @(posedge clk) begin
        if (phase == TX_IDLE && tx_trigger) begin
            shift_q <= tx_word;
        end else if (phase != TX_IDLE && phase != TX_STOP && cnt == CNT_W'(CLKS - 1)) begin
            shift_q <= {1'b0, shift_q[31:1]};
        end
    end

    assign tx_ready = (phase == TX_IDLE);

    // the scheduler must wait for ready, a trigger mid-frame would be lost
    a_no_trigger_busy: assert property (
        @(posedge clk) disable iff (rst) tx_trigger |-> tx_ready
    );

endmodule

// ==== design/tx_scheduler.sv ====
`timescale 1ns/1ps
`include "link_defs.svh"

module tx_scheduler (
    input  logic                   clk,
    input  logic                   rst,
    input  link_pkg::player_id_t   player_id,
    input  link_pkg::player_info_t local_info,
    input  link_pkg::gstate_t      local_game_state,
    input  logic                   credit_return,
    input  logic                   tx_ready,
    output link_pkg::word_t        tx_word,
    output logic                   tx_trigger,
    output link_pkg::sched_state_t link_status
);
    import link_pkg::*;

    localparam int CRED_W = $clog2(`LINK_CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`LINK_CREDITS);

    link_packet_t      cur_pkt;
    link_packet_t      last_sent;
    logic [CRED_W-1:0] credits;
    logic              has_credit;
    logic              changed;
    sched_state_t      state;
    sched_state_t      state_next;

    // encoded local record, refreshed every cycle
    always_ff @(posedge clk) begin
        cur_pkt.sender <= player_id;
        cur_pkt.info   <= local_info;
        cur_pkt.game   <= (player_id == '0) ? local_game_state : '0;
        cur_pkt.ptype  <= `LINK_PTYPE_PLAYER;
    end

    assign has_credit = (credits != '0);
    assign changed    = (cur_pkt != last_sent);
    // always the newest record goes out, older changes just merge into it
    assign tx_trigger = changed && has_credit && tx_ready;
    assign tx_word    = word_t'(cur_pkt);

    always_ff @(posedge clk) begin
        if (rst) begin
            last_sent <= '0;
        end else if (tx_trigger) begin
            last_sent <= cur_pkt;
        end
    end

    // spend on send, refill on ACK, both at once leaves the count alone
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CRED_MAX;
        end else begin
            case ({tx_trigger, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (credits != CRED_MAX) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            SCHED_IDLE: begin
                if (changed) begin
                    state_next = has_credit ? SCHED_SEND : SCHED_HOLD;
                end
            end
            SCHED_SEND: begin
                if (changed && !has_credit) begin
                    state_next = SCHED_HOLD;
                end else if (!changed && tx_ready) begin
                    state_next = SCHED_IDLE;
                end
            end
            SCHED_HOLD: begin
                // record went back to what was last sent
                if (has_credit) begin
                    state_next = SCHED_SEND;
                end else if (!changed) begin
                    state_next = SCHED_IDLE;
                end
            end
            default: state_next = SCHED_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCHED_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign link_status = state;

    a_credit_bounds: assert property (
        @(posedge clk) disable iff (rst)
        (credits <= CRED_MAX) && !(tx_trigger && credits == '0)
    );

endmodule

// ==== game_link.f ====
+incdir+design
design/link_pkg.sv
design/serial_rx.sv
design/serial_tx.sv
design/player_table.sv
design/tx_scheduler.sv
design/game_link.sv
tests/game_link_tb.sv

// ==== tests/game_link_tb.sv ====
`timescale 1ns/1ps
`include "link_defs.svh"

module game_link_tb;
    import link_pkg::*;

    localparam int CLKS           = `LINK_CLKS_PER_BIT;
    localparam int FRAME_CYCLES   = 34 * CLKS;
    localparam int PLANNED_FRAMES = 30 + `LINK_CREDITS;

    logic                   clk;
    logic                   rst;
    player_id_t             player_id;
    player_info_t           local_info;
    gstate_t                local_game_state;
    logic                   line_in;
    logic                   line_out;
    player_info_t [3:0]     players;
    gstate_t                game_state;
    sched_state_t           link_status;

    // model of the table and the frames seen on line_out
    player_info_t [3:0]     model_players = '0;
    gstate_t                model_gs = '0;
    word_t                  tx_frames[$];
    word_t                  exp_q[$];
    int                     frames_seen = 0;
    logic                   table_due = 1'b0;
    logic [15:0]            lfsr = 16'd13;
    int                     checks = 0;
    int                     errors = 0;

    game_link DUT (
        .clk              (clk),
        .rst              (rst),
        .player_id        (player_id),
        .local_info       (local_info),
        .local_game_state (local_game_state),
        .line_in          (line_in),
        .line_out         (line_out),
        .players          (players),
        .game_state       (game_state),
        .link_status      (link_status)
    );

    always #5 clk = ~clk;

    task automatic check_equal(input string what, input logic [95:0] got,
                               input logic [95:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic player_info_t make_info(input dir_t d, input coord_t x, input coord_t y,
                                               input pstate_t s);
        player_info_t p;
        p.dir   = d;
        p.x     = x;
        p.y     = y;
        p.state = s;
        return p;
    endfunction

    function automatic link_packet_t random_player_packet();
        link_packet_t p;
        p.sender = player_id_t'(rand_bits(2));
        p.info   = player_info_t'(rand_bits(24));
        p.game   = gstate_t'(rand_bits(3));
        p.ptype  = `LINK_PTYPE_PLAYER;
        return p;
    endfunction

    function automatic word_t ack_word();
        link_packet_t p;
        p       = '0;
        p.ptype = `LINK_PTYPE_ACK;
        return word_t'(p);
    endfunction

    // sender id, record, game field only from player zero, player type
    function automatic word_t expected_packet(input player_id_t id, input player_info_t info,
                                              input gstate_t gs);
        link_packet_t p;
        p.sender = id;
        p.info   = info;
        p.game   = (id == 2'd0) ? gs : 3'd0;
        p.ptype  = `LINK_PTYPE_PLAYER;
        return word_t'(p);
    endfunction

    // remote player packets fill their slot while acks and unknown types change nothing
    function automatic void expected_table(input word_t w);
        link_packet_t p;
        p = link_packet_t'(w);
        if (p.ptype == `LINK_PTYPE_PLAYER && p.sender != player_id) begin
            model_players[p.sender] = p.info;
            if (player_id != 2'd0 && p.sender == 2'd0) begin
                model_gs = p.game;
            end
        end
    endfunction

    task automatic send_frame(input word_t w, input logic stop_bit);
        @(posedge clk);
        line_in <= 1'b0;
        repeat (CLKS) @(posedge clk);
        for (int i = 0; i < 32; i++) begin
            line_in <= w[i];
            repeat (CLKS) @(posedge clk);
        end
        line_in <= stop_bit;
        repeat (CLKS) @(posedge clk);
        // idle gap before the next frame
        line_in <= 1'b1;
        repeat (2 * CLKS) @(posedge clk);
    endtask

    task automatic hub_packet(input word_t w, input logic stop_bit);
        send_frame(w, stop_bit);
        if (stop_bit) begin
            expected_table(w);
        end
        table_due = 1'b1;
        while (table_due) @(posedge clk);
    endtask

    task automatic set_local(input player_id_t id, input player_info_t info, input gstate_t gs);
        @(posedge clk);
        player_id        <= id;
        local_info       <= info;
        local_game_state <= gs;
        model_players[id] = info;
        if (id == 2'd0) begin
            model_gs = gs;
        end
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (frames_seen < target && cycles < 3 * FRAME_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (frames_seen < target) begin
            errors++;
            $display("timeout at %0t ns waiting for frame %0d on line_out", $time, target);
        end
    endtask

    task automatic send_local(input player_id_t id, input player_info_t info, input gstate_t gs,
                              input bit give_ack);
        int target;
        target = frames_seen + 1;
        exp_q.push_back(expected_packet(id, info, gs));
        set_local(id, info, gs);
        wait_frames(target);
        if (give_ack) begin
            hub_packet(ack_word(), 1'b1);
        end
    endtask

    task automatic quiet_window();
        repeat (FRAME_CYCLES + 4 * CLKS) @(posedge clk);
    endtask

    // hub receiver sampling line_out near the middle of each bit
    initial begin : hub_rx
        word_t w;
        wait (rst === 1'b0);
        forever begin
            @(posedge clk);
            if (line_out === 1'b0) begin
                repeat (CLKS / 2) @(posedge clk);
                if (line_out === 1'b0) begin
                    for (int i = 0; i < 32; i++) begin
                        repeat (CLKS) @(posedge clk);
                        w[i] = line_out;
                    end
                    repeat (CLKS) @(posedge clk);
                    if (line_out === 1'b1) begin
                        tx_frames.push_back(w);
                    end else begin
                        errors++;
                        $display("frame on line_out ended without a stop bit at %0t ns", $time);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin : frame_compare
        word_t got;
        if (tx_frames.size() > 0) begin
            got = tx_frames.pop_front();
            frames_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected frame %h on line_out at %0t ns", got, $time);
            end else begin
                check_equal("tx frame", 96'(got), 96'(exp_q.pop_front()));
            end
        end
        if (table_due) begin
            check_equal("players", players, model_players);
            check_equal("game_state", 96'(game_state), 96'(model_gs));
            table_due = 1'b0;
        end
    end

    // twice the frames x bit periods x clock period
    initial begin
        #(PLANNED_FRAMES * 34 * CLKS * 10 * 2);
        $display("watchdog expired, the run did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        link_packet_t pkt;
        int           seen;
        clk              = 1'b0;
        rst              = 1'b1;
        player_id        = '0;
        local_info       = '0;
        local_game_state = '0;
        line_in          = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // quiet link after reset
        quiet_window();
        check_equal("line_out after reset", 96'(line_out), 96'(1));
        check_equal("link_status after reset", 96'(link_status), 96'(SCHED_IDLE));
        check_equal("players after reset", players, 96'd0);
        check_equal("game_state after reset", 96'(game_state), 96'd0);
        check_equal("frames after reset", 96'(frames_seen), 96'd0);

        // one frame per local change
        send_local(2'd0, make_info(2'd1, 9'd100, 9'd50, 4'd3), 3'd5, 1'b1);
        send_local(2'd0, make_info(2'd1, 9'd101, 9'd50, 4'd3), 3'd5, 1'b1);
        send_local(2'd0, make_info(2'd1, 9'd101, 9'd50, 4'd3), 3'd2, 1'b1);
        seen = frames_seen;
        set_local(2'd0, make_info(2'd1, 9'd101, 9'd50, 4'd3), 3'd2);
        quiet_window();
        check_equal("frames for unchanged record", 96'(frames_seen), 96'(seen));
        check_equal("link_status when settled", 96'(link_status), 96'(SCHED_IDLE));

        // remote packets first as player zero and then as player two
        for (int i = 0; i < 4; i++) begin
            hub_packet(word_t'(random_player_packet()), 1'b1);
        end
        pkt        = random_player_packet();
        pkt.sender = player_id;
        hub_packet(word_t'(pkt), 1'b1);
        send_local(2'd2, make_info(2'd3, 9'd200, 9'd17, 4'd9), 3'd6, 1'b1);
        for (int i = 0; i < 4; i++) begin
            hub_packet(word_t'(random_player_packet()), 1'b1);
        end
        pkt        = random_player_packet();
        pkt.sender = 2'd0;
        hub_packet(word_t'(pkt), 1'b1);
        pkt        = random_player_packet();
        pkt.sender = 2'd2;
        hub_packet(word_t'(pkt), 1'b1);

        // credits run out and later changes merge into one frame
        for (int i = 0; i < `LINK_CREDITS; i++) begin
            send_local(2'd2, make_info(2'd0, coord_t'(10 + i), 9'd20, 4'd1), 3'd6, 1'b0);
        end
        seen = frames_seen;
        set_local(2'd2, make_info(2'd0, 9'd12, 9'd21, 4'd2), 3'd6);
        repeat (4 * CLKS) @(posedge clk);
        set_local(2'd2, make_info(2'd2, 9'd13, 9'd22, 4'd4), 3'd6);
        quiet_window();
        check_equal("frames without credit", 96'(frames_seen), 96'(seen));
        check_equal("link_status without credit", 96'(link_status), 96'(SCHED_HOLD));
        exp_q.push_back(expected_packet(2'd2, make_info(2'd2, 9'd13, 9'd22, 4'd4), 3'd6));
        hub_packet(ack_word(), 1'b1);
        wait_frames(seen + 1);
        quiet_window();
        check_equal("frames after one ack", 96'(frames_seen), 96'(seen + 1));
        check_equal("link_status after one ack", 96'(link_status), 96'(SCHED_IDLE));

        // ack, unknown type and broken stop bit leave the table alone
        pkt       = random_player_packet();
        pkt.ptype = `LINK_PTYPE_ACK;
        hub_packet(word_t'(pkt), 1'b1);
        pkt       = random_player_packet();
        pkt.ptype = 3'b011;
        hub_packet(word_t'(pkt), 1'b1);
        pkt        = random_player_packet();
        pkt.sender = 2'd1;
        hub_packet(word_t'(pkt), 1'b0);
        hub_packet(word_t'(random_player_packet()), 1'b1);
        check_equal("frames still expected", 96'(exp_q.size()), 96'd0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
